// File: dv/pad_ctrl_checker.sv
//////////////////////////////////////////////////////////////////////
// Checker for the pad multiplexer that tracks the select writes,
// predicts every pad and peripheral output and counts mismatches
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pad_ctrl_checker (
   input  logic                                 clk_i,
   input  logic                                 arst_n_i,
   input  string                                test_name_i,
   input  logic                                 cfg_we_i,
   input  logic [pad_ctrl_pkg::PAD_IDX_W-1:0]   cfg_addr_i,
   input  pad_ctrl_pkg::pad_func_e              cfg_func_i,
   input  pad_ctrl_pkg::pad_cfg_t               cfg_pad_i,
   input  logic                                 spi_clk_i,
   input  logic [pad_ctrl_pkg::N_CSN-1:0]       spi_csn_i,
   input  logic [pad_ctrl_pkg::SPI_LANES-1:0]   spi_sdo_i,
   input  logic [pad_ctrl_pkg::SPI_LANES-1:0]   spi_oen_i,
   input  logic [pad_ctrl_pkg::SPI_LANES-1:0]   spi_sdi_o,
   input  logic                                 uart_tx_i,
   input  logic                                 uart_rx_o,
   input  logic [pad_ctrl_pkg::N_I2C-1:0]       i2c_sda_out_i,
   input  logic [pad_ctrl_pkg::N_I2C-1:0]       i2c_sda_oe_i,
   input  logic [pad_ctrl_pkg::N_I2C-1:0]       i2c_sda_in_o,
   input  logic [pad_ctrl_pkg::N_I2C-1:0]       i2c_scl_out_i,
   input  logic [pad_ctrl_pkg::N_I2C-1:0]       i2c_scl_oe_i,
   input  logic [pad_ctrl_pkg::N_I2C-1:0]       i2c_scl_in_o,
   input  logic [pad_ctrl_pkg::N_PADS-1:0]      gpio_out_i,
   input  logic [pad_ctrl_pkg::N_PADS-1:0]      gpio_dir_i,
   input  logic [pad_ctrl_pkg::N_PADS-1:0]      gpio_in_o,
   input  pad_ctrl_pkg::pad_cfg_vec_t           gpio_cfg_i,
   input  logic [pad_ctrl_pkg::N_PADS-1:0]      pad_out_o,
   input  logic [pad_ctrl_pkg::N_PADS-1:0]      pad_oe_o,
   input  logic [pad_ctrl_pkg::N_PADS-1:0]      pad_in_i,
   input  pad_ctrl_pkg::pad_cfg_vec_t           pad_cfg_o,
   output int                                   err_cnt_o,
   output int                                   chk_cnt_o
);

   import pad_ctrl_pkg::*;

   pad_func_e model_func [N_PADS];
   pad_cfg_t  model_cfg  [N_PADS];
   int        errors = 0;
   int        checks = 0;

   assign err_cnt_o = errors;
   assign chk_cnt_o = checks;

   // Expected select state without the out-of-range writes
   always @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int p = 0; p < N_PADS; p++) begin
            model_func[p] <= FUNC_NONE;
            model_cfg[p]  <= '0;
         end
      end else if (cfg_we_i && (int'(cfg_addr_i) < N_PADS)) begin
         model_func[cfg_addr_i] <= cfg_func_i;
         model_cfg[cfg_addr_i]  <= cfg_pad_i;
      end
   end

   task automatic compare_value(input string what, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
      checks++;
      if (exp_v !== act_v) begin
         errors++;
         $display("MISMATCH %s %s expected %0h actual %0h", test_name_i, what, exp_v, act_v);
      end
   endtask

   // Peripheral drive per pad as {oe, out}
   function automatic logic [1:0] periph_drive(input int p);
      case (p)
         PAD_SPI_SDIO0: return {~spi_oen_i[0], spi_sdo_i[0]};
         PAD_SPI_SDIO1: return {~spi_oen_i[1], spi_sdo_i[1]};
         PAD_SPI_SDIO2: return {~spi_oen_i[2], spi_sdo_i[2]};
         PAD_SPI_SDIO3: return {~spi_oen_i[3], spi_sdo_i[3]};
         PAD_SPI_CSN0:  return {1'b1, spi_csn_i[0]};
         PAD_SPI_CSN1:  return {1'b1, spi_csn_i[1]};
         PAD_SPI_SCK:   return {1'b1, spi_clk_i};
         PAD_UART_TX:   return {1'b1, uart_tx_i};
         PAD_I2C0_SDA:  return {i2c_sda_oe_i[0], i2c_sda_out_i[0]};
         PAD_I2C0_SCL:  return {i2c_scl_oe_i[0], i2c_scl_out_i[0]};
         default:       return 2'b00;
      endcase
   endfunction

   // I2C1 on its alternate pads
   function automatic logic [1:0] alt_drive(input int p);
      case (p)
         PAD_SPI_SDIO2, PAD_UART_RX: return {i2c_sda_oe_i[1], i2c_sda_out_i[1]};
         PAD_SPI_SDIO3, PAD_UART_TX: return {i2c_scl_oe_i[1], i2c_scl_out_i[1]};
         default:                    return 2'b00;
      endcase
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Mid-cycle compare after the inputs have settled
   //////////////////////////////////////////////////////////////////////

   always @(negedge clk_i) begin
      logic [N_PADS-1:0]    exp_out;
      logic [N_PADS-1:0]    exp_oe;
      logic [N_PADS-1:0]    exp_gpio_in;
      logic [SPI_LANES-1:0] exp_sdi;
      logic [N_I2C-1:0]     exp_sda_in;
      logic [N_I2C-1:0]     exp_scl_in;
      logic                 exp_uart_rx;
      logic [1:0]           drv;
      pad_cfg_t             exp_cfg;
      for (int p = 0; p < N_PADS; p++) begin
         case (model_func[p])
            FUNC_PERIPH: drv = periph_drive(p);
            FUNC_GPIO:   drv = {gpio_dir_i[p], gpio_out_i[p]};
            FUNC_ALT:    drv = alt_drive(p);
            default:     drv = 2'b00;
         endcase
         exp_out[p]     = drv[0];
         exp_oe[p]      = drv[1];
         exp_gpio_in[p] = (model_func[p] == FUNC_GPIO) ? pad_in_i[p] : 1'b0;
         exp_cfg        = (model_func[p] == FUNC_GPIO) ? gpio_cfg_i[p] : model_cfg[p];
         compare_value($sformatf("pad_cfg[%0d]", p), 32'(exp_cfg), 32'(pad_cfg_o[p]));
      end
      for (int l = 0; l < SPI_LANES; l++) begin
         exp_sdi[l] = (model_func[PAD_SPI_SDIO0 + l] == FUNC_PERIPH)
                    ? pad_in_i[PAD_SPI_SDIO0 + l] : 1'b0;
      end
      exp_uart_rx   = (model_func[PAD_UART_RX] == FUNC_PERIPH) ? pad_in_i[PAD_UART_RX] : 1'b1;
      exp_sda_in[0] = (model_func[PAD_I2C0_SDA] == FUNC_PERIPH) ? pad_in_i[PAD_I2C0_SDA] : 1'b1;
      exp_scl_in[0] = (model_func[PAD_I2C0_SCL] == FUNC_PERIPH) ? pad_in_i[PAD_I2C0_SCL] : 1'b1;
      // SPI data pad has priority over the UART pad
      exp_sda_in[1] = (model_func[PAD_SPI_SDIO2] == FUNC_ALT) ? pad_in_i[PAD_SPI_SDIO2]
                    : (model_func[PAD_UART_RX] == FUNC_ALT)   ? pad_in_i[PAD_UART_RX] : 1'b1;
      exp_scl_in[1] = (model_func[PAD_SPI_SDIO3] == FUNC_ALT) ? pad_in_i[PAD_SPI_SDIO3]
                    : (model_func[PAD_UART_TX] == FUNC_ALT)   ? pad_in_i[PAD_UART_TX] : 1'b1;
      compare_value("pad_out", 32'(exp_out), 32'(pad_out_o));
      compare_value("pad_oe", 32'(exp_oe), 32'(pad_oe_o));
      compare_value("spi_sdi", 32'(exp_sdi), 32'(spi_sdi_o));
      compare_value("uart_rx", 32'(exp_uart_rx), 32'(uart_rx_o));
      compare_value("i2c_sda_in", 32'(exp_sda_in), 32'(i2c_sda_in_o));
      compare_value("i2c_scl_in", 32'(exp_scl_in), 32'(i2c_scl_in_o));
      compare_value("gpio_in", 32'(exp_gpio_in), 32'(gpio_in_o));
   end

endmodule

// File: dv/pad_ctrl_props.sv
//////////////////////////////////////////////////////////////////////
// Bound assertions on the pad multiplexer for quiet pads in reset,
// unused pads never enabled and I2C0 SDA idling high when unselected
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pad_ctrl_props (
   input logic                              clk_i,
   input logic                              arst_n_i,
   input pad_ctrl_pkg::pad_func_vec_t       func_sel_i,
   input logic [pad_ctrl_pkg::N_PADS-1:0]   pad_oe_i,
   input logic [pad_ctrl_pkg::N_I2C-1:0]    i2c_sda_in_i
);

   import pad_ctrl_pkg::*;

   int assert_fails = 0;

   // Nothing drives the ring while reset is held
   oe_low_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> (pad_oe_i == '0))
      else begin
         assert_fails++;
         $error("pad output enable set while reset is asserted");
      end

   for (genvar p = 0; p < N_PADS; p++) begin : g_pad
      none_not_enabled: assert property (@(posedge clk_i)
         (func_sel_i[p] == FUNC_NONE) |-> !pad_oe_i[p])
         else begin
            assert_fails++;
            $error("pad %0d enabled while its function is none", p);
         end
   end

   // Released bus reads high
   i2c0_sda_idle: assert property (@(posedge clk_i)
      (func_sel_i[PAD_I2C0_SDA] != FUNC_PERIPH) |-> i2c_sda_in_i[0])
      else begin
         assert_fails++;
         $error("I2C0 SDA input low while its pad is not on the peripheral");
      end

endmodule

bind pad_ctrl_top pad_ctrl_props u_props (
   .clk_i        (clk_i),
   .arst_n_i     (arst_n_i),
   .func_sel_i   (func_sel),
   .pad_oe_i     (pad_oe_o),
   .i2c_sda_in_i (i2c_sda_in_o)
);

// File: dv/tb_pad_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the pad multiplexer with clock and reset, a table of
// select writes under random pad and peripheral traffic, a timeout
// and the closing summary
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_pad_ctrl;

   import pad_ctrl_pkg::*;

   localparam int N_TESTS    = 22;
   localparam int RST_CYCLES = 16;
   localparam int MAX_CYCLES = N_TESTS * 4 + RST_CYCLES + 50;

   logic                 clk_i = 1'b0;
   logic                 arst_n_i;
   logic                 cfg_we_i;
   logic [PAD_IDX_W-1:0] cfg_addr_i;
   pad_func_e            cfg_func_i;
   pad_cfg_t             cfg_pad_i;
   logic                 spi_clk_i;
   logic [N_CSN-1:0]     spi_csn_i;
   logic [SPI_LANES-1:0] spi_sdo_i;
   logic [SPI_LANES-1:0] spi_oen_i;
   logic [SPI_LANES-1:0] spi_sdi_o;
   logic                 uart_tx_i;
   logic                 uart_rx_o;
   logic [N_I2C-1:0]     i2c_sda_out_i;
   logic [N_I2C-1:0]     i2c_sda_oe_i;
   logic [N_I2C-1:0]     i2c_sda_in_o;
   logic [N_I2C-1:0]     i2c_scl_out_i;
   logic [N_I2C-1:0]     i2c_scl_oe_i;
   logic [N_I2C-1:0]     i2c_scl_in_o;
   logic [N_PADS-1:0]    gpio_out_i;
   logic [N_PADS-1:0]    gpio_dir_i;
   logic [N_PADS-1:0]    gpio_in_o;
   pad_cfg_vec_t         gpio_cfg_i;
   logic [N_PADS-1:0]    pad_out_o;
   logic [N_PADS-1:0]    pad_oe_o;
   logic [N_PADS-1:0]    pad_in_i;
   pad_cfg_vec_t         pad_cfg_o;

   // Stimulus table
   string     tst_name [N_TESTS];
   int        tst_addr [N_TESTS];
   pad_func_e tst_func [N_TESTS];
   pad_cfg_t  tst_cfg  [N_TESTS];

   string cur_name;
   int    err_cnt;
   int    chk_cnt;
   int    cycles = 0;

   pad_ctrl_top dut (.*);

   pad_ctrl_checker chk (
      .*,
      .test_name_i (cur_name),
      .err_cnt_o   (err_cnt),
      .chk_cnt_o   (chk_cnt)
   );

   always #4 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("test failed");
         $finish;
      end
   end

   task automatic load_entry(input int idx, input string name, input int addr,
                             input pad_func_e func, input pad_cfg_t cfg);
      tst_name[idx] = name;
      tst_addr[idx] = addr;
      tst_func[idx] = func;
      tst_cfg[idx]  = cfg;
   endtask

   task automatic drive_random();
      spi_clk_i     = 1'($urandom());
      spi_csn_i     = N_CSN'($urandom());
      spi_sdo_i     = SPI_LANES'($urandom());
      spi_oen_i     = SPI_LANES'($urandom());
      uart_tx_i     = 1'($urandom());
      i2c_sda_out_i = N_I2C'($urandom());
      i2c_sda_oe_i  = N_I2C'($urandom());
      i2c_scl_out_i = N_I2C'($urandom());
      i2c_scl_oe_i  = N_I2C'($urandom());
      gpio_out_i    = N_PADS'($urandom());
      gpio_dir_i    = N_PADS'($urandom());
      pad_in_i      = N_PADS'($urandom());
      for (int p = 0; p < N_PADS; p++) begin
         gpio_cfg_i[p] = PAD_CFG_W'($urandom());
      end
   endtask

   initial begin
      void'($urandom(32'h5320));
      arst_n_i      = 1'b1;
      cfg_we_i      = 1'b0;
      cfg_addr_i    = '0;
      cfg_func_i    = FUNC_NONE;
      cfg_pad_i     = '0;
      spi_clk_i     = 1'b0;
      spi_csn_i     = '0;
      spi_sdo_i     = '0;
      spi_oen_i     = '0;
      uart_tx_i     = 1'b0;
      i2c_sda_out_i = '0;
      i2c_sda_oe_i  = '0;
      i2c_scl_out_i = '0;
      i2c_scl_oe_i  = '0;
      gpio_out_i    = '0;
      gpio_dir_i    = '0;
      gpio_cfg_i    = '0;
      pad_in_i      = '0;
      cur_name      = "reset";

      // Every pad on its own peripheral first
      for (int p = 0; p < N_PADS; p++) begin
         load_entry(p, $sformatf("periph_pad%0d", p), p, FUNC_PERIPH, PAD_CFG_W'(p + 1));
      end
      load_entry(11, "gpio_sdio1", PAD_SPI_SDIO1, FUNC_GPIO, 6'h2a);
      load_entry(12, "gpio_i2c0_scl", PAD_I2C0_SCL, FUNC_GPIO, 6'h15);
      // I2C1 on the UART pads and then also on SPI data 2 and 3
      load_entry(13, "alt_uart_rx", PAD_UART_RX, FUNC_ALT, 6'h31);
      load_entry(14, "alt_uart_tx", PAD_UART_TX, FUNC_ALT, 6'h32);
      load_entry(15, "alt_sdio2", PAD_SPI_SDIO2, FUNC_ALT, 6'h33);
      load_entry(16, "alt_sdio3", PAD_SPI_SDIO3, FUNC_ALT, 6'h34);
      load_entry(17, "oob_addr_11", 11, FUNC_GPIO, 6'h3f);
      load_entry(18, "oob_addr_15", 15, FUNC_PERIPH, 6'h3e);
      load_entry(19, "none_sdio2", PAD_SPI_SDIO2, FUNC_NONE, 6'h0c);
      load_entry(20, "none_uart_rx", PAD_UART_RX, FUNC_NONE, 6'h0d);
      load_entry(21, "alt_sck", PAD_SPI_SCK, FUNC_ALT, 6'h1b);

      // Reset edge after time zero so the registers see it
      #1 arst_n_i = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_i);
      #1;
      arst_n_i = 1'b1;
      cur_name = "after_reset";
      drive_random();
      repeat (2) @(posedge clk_i);
      #1;

      for (int i = 0; i < N_TESTS; i++) begin
         cur_name   = tst_name[i];
         cfg_we_i   = 1'b1;
         cfg_addr_i = PAD_IDX_W'(tst_addr[i]);
         cfg_func_i = tst_func[i];
         cfg_pad_i  = tst_cfg[i];
         @(posedge clk_i);
         #1;
         cfg_we_i = 1'b0;
         drive_random();
         repeat (2) @(posedge clk_i);
         #1;
      end

      $display("Checks: %0d, mismatches: %0d, assertion failures: %0d", chk_cnt, err_cnt,
               dut.u_props.assert_fails);
      if (err_cnt == 0 && dut.u_props.assert_fails == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: rtl/pad_ctrl_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared definitions of the pad multiplexer with pad count and indices,
// peripheral widths, the pad function select and the pad config types
//////////////////////////////////////////////////////////////////////

package pad_ctrl_pkg;

   //////////////////////////////////////////////////////////////////////
   // Sizes
   //////////////////////////////////////////////////////////////////////

   localparam int N_PADS    = 11;
   localparam int PAD_IDX_W = $clog2(N_PADS);
   localparam int SPI_LANES = 4;
   localparam int N_CSN     = 2;
   localparam int N_I2C     = 2;

   // Electrical pad configuration (drive strength, pulls, etc.)
   localparam int PAD_CFG_W = 6;

   //////////////////////////////////////////////////////////////////////
   // Pad indices in the ring
   //////////////////////////////////////////////////////////////////////

   localparam int PAD_SPI_SDIO0 = 0;
   localparam int PAD_SPI_SDIO1 = 1;
   localparam int PAD_SPI_SDIO2 = 2;
   localparam int PAD_SPI_SDIO3 = 3;
   localparam int PAD_SPI_CSN0  = 4;
   localparam int PAD_SPI_CSN1  = 5;
   localparam int PAD_SPI_SCK   = 6;
   localparam int PAD_UART_RX   = 7;
   localparam int PAD_UART_TX   = 8;
   localparam int PAD_I2C0_SDA  = 9;
   localparam int PAD_I2C0_SCL  = 10;

   //////////////////////////////////////////////////////////////////////
   // Types
   //////////////////////////////////////////////////////////////////////

   typedef logic [PAD_CFG_W-1:0] pad_cfg_t;

   // Function select per pad
   typedef enum logic [1:0] {
      FUNC_PERIPH = 2'd0,
      FUNC_GPIO   = 2'd1,
      FUNC_ALT    = 2'd2,
      FUNC_NONE   = 2'd3
   } pad_func_e;

   typedef pad_func_e [N_PADS-1:0] pad_func_vec_t;
   typedef pad_cfg_t  [N_PADS-1:0] pad_cfg_vec_t;

endpackage

// File: rtl/pad_ctrl_top.sv
//////////////////////////////////////////////////////////////////////
// Pad multiplexer top level with the config registers, the pad drive
// mux, the pad input demux and the peripheral bundle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pad_ctrl_top (
   input  logic                                 clk_i,
   input  logic                                 arst_n_i,

   // Configuration write port
   input  logic                                 cfg_we_i,
   input  logic [pad_ctrl_pkg::PAD_IDX_W-1:0]   cfg_addr_i,
   input  pad_ctrl_pkg::pad_func_e              cfg_func_i,
   input  pad_ctrl_pkg::pad_cfg_t               cfg_pad_i,

   // SPI master
   input  logic                                 spi_clk_i,
   input  logic [pad_ctrl_pkg::N_CSN-1:0]       spi_csn_i,
   input  logic [pad_ctrl_pkg::SPI_LANES-1:0]   spi_sdo_i,
   input  logic [pad_ctrl_pkg::SPI_LANES-1:0]   spi_oen_i,
   output logic [pad_ctrl_pkg::SPI_LANES-1:0]   spi_sdi_o,

   // UART
   input  logic                                 uart_tx_i,
   output logic                                 uart_rx_o,

   // I2C
   input  logic [pad_ctrl_pkg::N_I2C-1:0]       i2c_sda_out_i,
   input  logic [pad_ctrl_pkg::N_I2C-1:0]       i2c_sda_oe_i,
   output logic [pad_ctrl_pkg::N_I2C-1:0]       i2c_sda_in_o,
   input  logic [pad_ctrl_pkg::N_I2C-1:0]       i2c_scl_out_i,
   input  logic [pad_ctrl_pkg::N_I2C-1:0]       i2c_scl_oe_i,
   output logic [pad_ctrl_pkg::N_I2C-1:0]       i2c_scl_in_o,

   // GPIO
   input  logic [pad_ctrl_pkg::N_PADS-1:0]      gpio_out_i,
   input  logic [pad_ctrl_pkg::N_PADS-1:0]      gpio_dir_i,
   output logic [pad_ctrl_pkg::N_PADS-1:0]      gpio_in_o,
   input  pad_ctrl_pkg::pad_cfg_vec_t           gpio_cfg_i,

   // Pad ring
   output logic [pad_ctrl_pkg::N_PADS-1:0]      pad_out_o,
   output logic [pad_ctrl_pkg::N_PADS-1:0]      pad_oe_o,
   input  logic [pad_ctrl_pkg::N_PADS-1:0]      pad_in_i,
   output pad_ctrl_pkg::pad_cfg_vec_t           pad_cfg_o
);

   import pad_ctrl_pkg::*;

   pad_func_vec_t func_sel;
   pad_cfg_vec_t  pad_cfg_dflt;

   periph_if u_periph ();

   //////////////////////////////////////////////////////////////////////
   // Peripheral ports into and out of the bundle
   //////////////////////////////////////////////////////////////////////

   assign u_periph.spi_clk     = spi_clk_i;
   assign u_periph.spi_csn     = spi_csn_i;
   assign u_periph.spi_sdo     = spi_sdo_i;
   assign u_periph.spi_oen     = spi_oen_i;
   assign u_periph.uart_tx     = uart_tx_i;
   assign u_periph.i2c_sda_out = i2c_sda_out_i;
   assign u_periph.i2c_sda_oe  = i2c_sda_oe_i;
   assign u_periph.i2c_scl_out = i2c_scl_out_i;
   assign u_periph.i2c_scl_oe  = i2c_scl_oe_i;
   assign u_periph.gpio_out    = gpio_out_i;
   assign u_periph.gpio_dir    = gpio_dir_i;
   assign u_periph.gpio_cfg    = gpio_cfg_i;

   assign spi_sdi_o    = u_periph.spi_sdi;
   assign uart_rx_o    = u_periph.uart_rx;
   assign i2c_sda_in_o = u_periph.i2c_sda_in;
   assign i2c_scl_in_o = u_periph.i2c_scl_in;
   assign gpio_in_o    = u_periph.gpio_in;

   //////////////////////////////////////////////////////////////////////
   // Config registers and the two muxing blocks side by side
   //////////////////////////////////////////////////////////////////////

   pad_mux_regs u_regs (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .cfg_we_i       (cfg_we_i),
      .cfg_addr_i     (cfg_addr_i),
      .cfg_func_i     (cfg_func_i),
      .cfg_pad_i      (cfg_pad_i),
      .func_sel_o     (func_sel),
      .pad_cfg_dflt_o (pad_cfg_dflt)
   );

   pad_drive_mux u_drive (
      .func_sel_i     (func_sel),
      .pad_cfg_dflt_i (pad_cfg_dflt),
      .periph         (u_periph.drv),
      .pad_out_o      (pad_out_o),
      .pad_oe_o       (pad_oe_o),
      .pad_cfg_o      (pad_cfg_o)
   );

   pad_in_demux u_in (
      .func_sel_i (func_sel),
      .pad_in_i   (pad_in_i),
      .periph     (u_periph.rcv)
   );

endmodule

// File: rtl/pad_drive_mux.sv
//////////////////////////////////////////////////////////////////////
// Pad output side with output value, output enable and electrical
// config per pad as picked by the pad's function select
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pad_drive_mux (
   input  pad_ctrl_pkg::pad_func_vec_t  func_sel_i,
   input  pad_ctrl_pkg::pad_cfg_vec_t   pad_cfg_dflt_i,
   periph_if.drv                        periph,
   output logic [pad_ctrl_pkg::N_PADS-1:0] pad_out_o,
   output logic [pad_ctrl_pkg::N_PADS-1:0] pad_oe_o,
   output pad_ctrl_pkg::pad_cfg_vec_t   pad_cfg_o
);

   import pad_ctrl_pkg::*;

   // Candidate drive per pad for the peripheral and alternate functions
   logic [N_PADS-1:0] per_out;
   logic [N_PADS-1:0] per_oe;
   logic [N_PADS-1:0] alt_out;
   logic [N_PADS-1:0] alt_oe;

   //////////////////////////////////////////////////////////////////////
   // Peripheral function
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      per_out = '0;
      per_oe  = '0;
      // SPI data lanes with active-low oen
      for (int l = 0; l < SPI_LANES; l++) begin
         per_out[PAD_SPI_SDIO0 + l] = periph.spi_sdo[l];
         per_oe[PAD_SPI_SDIO0 + l]  = ~periph.spi_oen[l];
      end
      for (int c = 0; c < N_CSN; c++) begin
         per_out[PAD_SPI_CSN0 + c] = periph.spi_csn[c];
         per_oe[PAD_SPI_CSN0 + c]  = 1'b1;
      end
      per_out[PAD_SPI_SCK]  = periph.spi_clk;
      per_oe[PAD_SPI_SCK]   = 1'b1;
      // UART rx pad is input only and keeps its zero default
      per_out[PAD_UART_TX]  = periph.uart_tx;
      per_oe[PAD_UART_TX]   = 1'b1;
      per_out[PAD_I2C0_SDA] = periph.i2c_sda_out[0];
      per_oe[PAD_I2C0_SDA]  = periph.i2c_sda_oe[0];
      per_out[PAD_I2C0_SCL] = periph.i2c_scl_out[0];
      per_oe[PAD_I2C0_SCL]  = periph.i2c_scl_oe[0];
   end

   //////////////////////////////////////////////////////////////////////
   // Alternate function carrying I2C channel 1
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      alt_out = '0;
      alt_oe  = '0;
      // SDA on SPI data 2 or UART rx
      alt_out[PAD_SPI_SDIO2] = periph.i2c_sda_out[1];
      alt_oe[PAD_SPI_SDIO2]  = periph.i2c_sda_oe[1];
      alt_out[PAD_UART_RX]   = periph.i2c_sda_out[1];
      alt_oe[PAD_UART_RX]    = periph.i2c_sda_oe[1];
      // SCL on SPI data 3 or UART tx
      alt_out[PAD_SPI_SDIO3] = periph.i2c_scl_out[1];
      alt_oe[PAD_SPI_SDIO3]  = periph.i2c_scl_oe[1];
      alt_out[PAD_UART_TX]   = periph.i2c_scl_out[1];
      alt_oe[PAD_UART_TX]    = periph.i2c_scl_oe[1];
   end

   //////////////////////////////////////////////////////////////////////
   // Per-pad selection
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int p = 0; p < N_PADS; p++) begin
         case (func_sel_i[p])
            FUNC_PERIPH: begin
               pad_out_o[p] = per_out[p];
               pad_oe_o[p]  = per_oe[p];
            end
            FUNC_GPIO: begin
               pad_out_o[p] = periph.gpio_out[p];
               pad_oe_o[p]  = periph.gpio_dir[p];
            end
            FUNC_ALT: begin
               pad_out_o[p] = alt_out[p];
               pad_oe_o[p]  = alt_oe[p];
            end
            default: begin
               pad_out_o[p] = 1'b0;
               pad_oe_o[p]  = 1'b0;
            end
         endcase
         // GPIO owns the pad config only while the pad is GPIO
         pad_cfg_o[p] = (func_sel_i[p] == FUNC_GPIO) ? periph.gpio_cfg[p]
                                                      : pad_cfg_dflt_i[p];
      end
   end

endmodule

// File: rtl/pad_in_demux.sv
//////////////////////////////////////////////////////////////////////
// Pad input side that routes pad inputs back to SPI, UART, I2C and
// GPIO with idle values on unselected pads
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pad_in_demux (
   input  pad_ctrl_pkg::pad_func_vec_t     func_sel_i,
   input  logic [pad_ctrl_pkg::N_PADS-1:0] pad_in_i,
   periph_if.rcv                           periph
);

   import pad_ctrl_pkg::*;

   //////////////////////////////////////////////////////////////////////
   // SPI and UART
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int l = 0; l < SPI_LANES; l++) begin
         periph.spi_sdi[l] = (func_sel_i[PAD_SPI_SDIO0 + l] == FUNC_PERIPH)
                           ? pad_in_i[PAD_SPI_SDIO0 + l] : 1'b0;
      end
   end

   // UART line idles high
   assign periph.uart_rx = (func_sel_i[PAD_UART_RX] == FUNC_PERIPH)
                         ? pad_in_i[PAD_UART_RX] : 1'b1;

   //////////////////////////////////////////////////////////////////////
   // I2C
   //////////////////////////////////////////////////////////////////////

   // Channel 0 reads high while its bus is released
   assign periph.i2c_sda_in[0] = (func_sel_i[PAD_I2C0_SDA] == FUNC_PERIPH)
                               ? pad_in_i[PAD_I2C0_SDA] : 1'b1;
   assign periph.i2c_scl_in[0] = (func_sel_i[PAD_I2C0_SCL] == FUNC_PERIPH)
                               ? pad_in_i[PAD_I2C0_SCL] : 1'b1;

   // Channel 1 prefers the SPI data pads over the UART pads
   always_comb begin
      if (func_sel_i[PAD_SPI_SDIO2] == FUNC_ALT) begin
         periph.i2c_sda_in[1] = pad_in_i[PAD_SPI_SDIO2];
      end else if (func_sel_i[PAD_UART_RX] == FUNC_ALT) begin
         periph.i2c_sda_in[1] = pad_in_i[PAD_UART_RX];
      end else begin
         periph.i2c_sda_in[1] = 1'b1;
      end
   end

   always_comb begin
      if (func_sel_i[PAD_SPI_SDIO3] == FUNC_ALT) begin
         periph.i2c_scl_in[1] = pad_in_i[PAD_SPI_SDIO3];
      end else if (func_sel_i[PAD_UART_TX] == FUNC_ALT) begin
         periph.i2c_scl_in[1] = pad_in_i[PAD_UART_TX];
      end else begin
         periph.i2c_scl_in[1] = 1'b1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // GPIO
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int p = 0; p < N_PADS; p++) begin
         periph.gpio_in[p] = (func_sel_i[p] == FUNC_GPIO) ? pad_in_i[p] : 1'b0;
      end
   end

endmodule

// File: rtl/pad_mux_regs.sv
//////////////////////////////////////////////////////////////////////
// Per-pad function select and default pad configuration registers
// that are written one pad at a time through a single-cycle strobe
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pad_mux_regs (
   input  logic                              clk_i,
   input  logic                              arst_n_i,
   input  logic                              cfg_we_i,
   input  logic [pad_ctrl_pkg::PAD_IDX_W-1:0] cfg_addr_i,
   input  pad_ctrl_pkg::pad_func_e           cfg_func_i,
   input  pad_ctrl_pkg::pad_cfg_t            cfg_pad_i,
   output pad_ctrl_pkg::pad_func_vec_t       func_sel_o,
   output pad_ctrl_pkg::pad_cfg_vec_t        pad_cfg_dflt_o
);

   import pad_ctrl_pkg::*;

   logic          addr_ok;
   logic [N_PADS-1:0] wr_sel;
   pad_func_vec_t func_q;
   pad_cfg_vec_t  cfg_q;

   //////////////////////////////////////////////////////////////////////
   // Write decode
   //////////////////////////////////////////////////////////////////////

   // Addresses past the last pad are dropped
   assign addr_ok = (int'(cfg_addr_i) < N_PADS);

   always_comb begin
      wr_sel = '0;
      if (cfg_we_i && addr_ok) begin
         wr_sel[cfg_addr_i] = 1'b1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Registers with one slot per pad
   //////////////////////////////////////////////////////////////////////

   for (genvar p = 0; p < N_PADS; p++) begin : g_pad
      always_ff @(posedge clk_i or negedge arst_n_i) begin
         if (!arst_n_i) begin
            // Pads come up unused
            func_q[p] <= FUNC_NONE;
            cfg_q[p]  <= '0;
         end else if (wr_sel[p]) begin
            func_q[p] <= cfg_func_i;
            cfg_q[p]  <= cfg_pad_i;
         end
      end
   end

   assign func_sel_o     = func_q;
   assign pad_cfg_dflt_o = cfg_q;

endmodule

// File: rtl/periph_if.sv
//////////////////////////////////////////////////////////////////////
// Peripheral side bundle of the pad multiplexer for SPI, UART, I2C
// and GPIO
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface periph_if;

   import pad_ctrl_pkg::*;

   // SPI master
   logic                 spi_clk;
   logic [N_CSN-1:0]     spi_csn;
   logic [SPI_LANES-1:0] spi_sdo;
   logic [SPI_LANES-1:0] spi_oen;
   logic [SPI_LANES-1:0] spi_sdi;

   // UART
   logic                 uart_tx;
   logic                 uart_rx;

   // I2C channel 0 on its own pads and channel 1 on alternate pads
   logic [N_I2C-1:0]     i2c_sda_out;
   logic [N_I2C-1:0]     i2c_sda_oe;
   logic [N_I2C-1:0]     i2c_sda_in;
   logic [N_I2C-1:0]     i2c_scl_out;
   logic [N_I2C-1:0]     i2c_scl_oe;
   logic [N_I2C-1:0]     i2c_scl_in;

   // GPIO, one bit per pad
   logic [N_PADS-1:0]    gpio_out;
   logic [N_PADS-1:0]    gpio_dir;
   logic [N_PADS-1:0]    gpio_in;
   pad_cfg_vec_t         gpio_cfg;

   // Toward the pads
   modport drv (
      input spi_clk, spi_csn, spi_sdo, spi_oen,
      input uart_tx,
      input i2c_sda_out, i2c_sda_oe, i2c_scl_out, i2c_scl_oe,
      input gpio_out, gpio_dir, gpio_cfg
   );

   // Back from the pads
   modport rcv (
      output spi_sdi, uart_rx, i2c_sda_in, i2c_scl_in, gpio_in
   );

endinterface

// File: run.sh
#!/usr/bin/env bash
# Build and run the pad multiplexer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   -f sources.f \
   --top-module tb_pad_ctrl \
   -o sim_pad_ctrl

./obj_dir/sim_pad_ctrl | tee sim.log

if grep -q "test failed" sim.log; then
   exit 1
fi

# A run that never reached its summary counts as a failure too
if ! grep -q "test passed" sim.log; then
   exit 1
fi

exit 0

// File: sources.f
rtl/pad_ctrl_pkg.sv
rtl/periph_if.sv
rtl/pad_mux_regs.sv
rtl/pad_drive_mux.sv
rtl/pad_in_demux.sv
rtl/pad_ctrl_top.sv
dv/pad_ctrl_props.sv
dv/pad_ctrl_checker.sv
dv/tb_pad_ctrl.sv
